/* design/fpIssue_cfg.svh */
//==========================================================
// Sizes for the FP issue path. Queue depth and data width
// are expected to be powers of two, and the lane count at
// least 2. Data width must be even for the sqrt loop.
//==========================================================
`ifndef FP_ISSUE_CFG_SVH
`define FP_ISSUE_CFG_SVH

// Issue queue entries
`define FP_QUEUE_DEPTH 8

// Lanes issued per cycle
`define FP_ISSUE_WIDTH 2

// Active-list pointer width
`define FP_TAG_WIDTH 5

// Operand and result width
`define FP_DATA_WIDTH 16

`endif

/* design/FpIssuePkg.sv */
//==========================================================
// Types shared by the FP issue path. Flush ranges wrap
// around the active list, head and tail both inclusive.
//==========================================================
`include "fpIssue_cfg.svh"

package FpIssuePkg;

    typedef logic [`FP_TAG_WIDTH-1:0] FpTag;
    typedef logic [`FP_DATA_WIDTH-1:0] FpData;
    typedef logic [$clog2(`FP_QUEUE_DEPTH)-1:0] FpQueueIndex;

    typedef enum logic [2:0] {
        opAdd,
        opSub,
        opMul,
        opDiv,
        opSqrt
    } FpOpKind;

    typedef struct packed {
        FpData srcA;
        FpData srcB;
    } FpArithView;

    // Divisor is ignored by sqrt
    typedef struct packed {
        FpData dividend;
        FpData divisor;
    } FpDivView;

    typedef union packed {
        FpArithView arith;
        FpDivView divSqrt;
    } FpOperands;

    typedef struct packed {
        logic valid;
        logic issued;
        FpOpKind kind;
        FpTag tag;
        FpOperands operands;
    } FpQueueEntry;

    typedef struct packed {
        logic valid;
        FpQueueIndex entryIdx;
        FpOpKind kind;
        FpTag tag;
        FpOperands operands;
    } FpIssueSlot;

    function automatic logic IsDivSqrt(input FpOpKind kind);
        return (kind == opDiv) || (kind == opSqrt);
    endfunction

    function automatic logic InFlushRange(input logic flushAll, input FpTag head,
                                          input FpTag tail, input FpTag tag);
        if (flushAll) begin
            return 1'b1;
        end
        // Range wraps when head is past tail
        if (head <= tail) begin
            return (tag >= head) && (tag <= tail);
        end
        return (tag >= head) || (tag <= tail);
    endfunction

endpackage

/* design/fpIssueQueue.sv */
//==========================================================
// Eight-entry FP issue queue. Every valid entry counts as
// ready. The stage reports done or replay one cycle after
// it captures a slot. Dispatch into a full queue is illegal.
//==========================================================
`timescale 1ns/1ps
`include "fpIssue_cfg.svh"

module fpIssueQueue (
    input  logic clk,
    input  logic reset,
    input  logic dispatchValid,
    input  FpIssuePkg::FpOpKind dispatchKind,
    input  FpIssuePkg::FpTag dispatchTag,
    input  FpIssuePkg::FpOperands dispatchOperands,
    output logic queueFull,
    input  logic stall,
    input  logic flushValid,
    input  logic flushAll,
    input  FpIssuePkg::FpTag flushHead,
    input  FpIssuePkg::FpTag flushTail,
    output FpIssuePkg::FpIssueSlot issueSlot [`FP_ISSUE_WIDTH],
    input  logic [`FP_ISSUE_WIDTH-1:0] issueDone,
    input  logic [`FP_ISSUE_WIDTH-1:0] issueReplay,
    input  FpIssuePkg::FpQueueIndex issueIndex [`FP_ISSUE_WIDTH]
);
    import FpIssuePkg::*;

    FpQueueEntry entries [`FP_QUEUE_DEPTH];
    FpQueueIndex freeIdx;

    // Lowest free entry and the two oldest-by-index unissued entries
    always_comb begin
        int picked;
        picked = 0;
        queueFull = 1'b1;
        freeIdx = '0;
        for (int i = `FP_QUEUE_DEPTH - 1; i >= 0; i--) begin
            if (!entries[i].valid) begin
                queueFull = 1'b0;
                freeIdx = FpQueueIndex'(i);
            end
        end
        for (int l = 0; l < `FP_ISSUE_WIDTH; l++) begin
            issueSlot[l] = '0;
        end
        for (int i = 0; i < `FP_QUEUE_DEPTH; i++) begin
            if (!stall && picked < `FP_ISSUE_WIDTH && entries[i].valid &&
                    !entries[i].issued) begin
                issueSlot[picked].valid = 1'b1;
                issueSlot[picked].entryIdx = FpQueueIndex'(i);
                issueSlot[picked].kind = entries[i].kind;
                issueSlot[picked].tag = entries[i].tag;
                issueSlot[picked].operands = entries[i].operands;
                picked++;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `FP_QUEUE_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].issued <= 1'b0;
            end
        end else begin
            // Later writes win: select, replay, done, flush, then dispatch
            for (int l = 0; l < `FP_ISSUE_WIDTH; l++) begin
                if (issueSlot[l].valid) begin
                    entries[issueSlot[l].entryIdx].issued <= 1'b1;
                end
                if (issueReplay[l]) begin
                    entries[issueIndex[l]].issued <= 1'b0;
                end
                if (issueDone[l]) begin
                    entries[issueIndex[l]].valid <= 1'b0;
                end
            end
            for (int i = 0; i < `FP_QUEUE_DEPTH; i++) begin
                if (flushValid && entries[i].valid &&
                        InFlushRange(flushAll, flushHead, flushTail, entries[i].tag)) begin
                    entries[i].valid <= 1'b0;
                end
            end
            // Free entry is never touched by the loops above
            if (dispatchValid && !queueFull) begin
                entries[freeIdx].valid <= 1'b1;
                entries[freeIdx].issued <= 1'b0;
                entries[freeIdx].kind <= dispatchKind;
                entries[freeIdx].tag <= dispatchTag;
                entries[freeIdx].operands <= dispatchOperands;
            end
        end
    end

    noDispatchWhenFull: assert property (
        @(posedge clk) disable iff (reset) dispatchValid |-> !queueFull
    );

endmodule

/* design/fpIssueStage.sv */
//==========================================================
// Two-lane FP issue stage. A held slot is processed in the
// cycle after capture. Div/sqrt slots that lose arbitration
// or meet a busy unit go back to the queue as replays.
//==========================================================
`timescale 1ns/1ps
`include "fpIssue_cfg.svh"

module fpIssueStage (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic flushValid,
    input  logic flushAll,
    input  FpIssuePkg::FpTag flushHead,
    input  FpIssuePkg::FpTag flushTail,
    input  FpIssuePkg::FpIssueSlot issueSlot [`FP_ISSUE_WIDTH],
    output logic [`FP_ISSUE_WIDTH-1:0] issueDone,
    output logic [`FP_ISSUE_WIDTH-1:0] issueReplay,
    output FpIssuePkg::FpQueueIndex issueIndex [`FP_ISSUE_WIDTH],
    output logic [`FP_ISSUE_WIDTH-1:0] divReq,
    input  logic [`FP_ISSUE_WIDTH-1:0] divGrant,
    input  logic divBusy,
    output logic divStart,
    output FpIssuePkg::FpOpKind divKind,
    output FpIssuePkg::FpTag divTag,
    output FpIssuePkg::FpOperands divOperands,
    output logic [`FP_ISSUE_WIDTH-1:0] resultValid,
    output FpIssuePkg::FpTag resultTag [`FP_ISSUE_WIDTH],
    output FpIssuePkg::FpData resultData [`FP_ISSUE_WIDTH]
);
    import FpIssuePkg::*;

    FpIssueSlot pipeReg [`FP_ISSUE_WIDTH];
    logic [`FP_ISSUE_WIDTH-1:0] heldHit, incomingHit, live, isDiv;

    always_comb begin
        for (int i = 0; i < `FP_ISSUE_WIDTH; i++) begin
            heldHit[i] = flushValid &&
                InFlushRange(flushAll, flushHead, flushTail, pipeReg[i].tag);
            incomingHit[i] = flushValid &&
                InFlushRange(flushAll, flushHead, flushTail, issueSlot[i].tag);
            live[i] = pipeReg[i].valid && !stall && !heldHit[i];
            isDiv[i] = IsDivSqrt(pipeReg[i].kind);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `FP_ISSUE_WIDTH; i++) begin
                pipeReg[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `FP_ISSUE_WIDTH; i++) begin
                if (!stall) begin
                    pipeReg[i] <= issueSlot[i];
                    pipeReg[i].valid <= issueSlot[i].valid && !incomingHit[i];
                end else if (heldHit[i]) begin
                    pipeReg[i].valid <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        divStart = |divGrant;
        divKind = pipeReg[0].kind;
        divTag = pipeReg[0].tag;
        divOperands = pipeReg[0].operands;
        for (int i = 0; i < `FP_ISSUE_WIDTH; i++) begin
            divReq[i] = live[i] && isDiv[i] && !divBusy;
            issueDone[i] = live[i] && (!isDiv[i] || divGrant[i]);
            issueReplay[i] = live[i] && isDiv[i] && !divGrant[i];
            issueIndex[i] = pipeReg[i].entryIdx;
            resultValid[i] = live[i] && !isDiv[i];
            resultTag[i] = pipeReg[i].tag;
            if (divGrant[i]) begin
                divKind = pipeReg[i].kind;
                divTag = pipeReg[i].tag;
                divOperands = pipeReg[i].operands;
            end
            // Wrapping arithmetic, low half of the product
            case (pipeReg[i].kind)
                opSub: resultData[i] = pipeReg[i].operands.arith.srcA -
                                       pipeReg[i].operands.arith.srcB;
                opMul: resultData[i] = pipeReg[i].operands.arith.srcA *
                                       pipeReg[i].operands.arith.srcB;
                default: resultData[i] = pipeReg[i].operands.arith.srcA +
                                         pipeReg[i].operands.arith.srcB;
            endcase
        end
    end

    doneOrReplay: assert property (
        @(posedge clk) disable iff (reset) (issueDone & issueReplay) == '0
    );

    noStartWhileBusy: assert property (
        @(posedge clk) disable iff (reset) divStart |-> !divBusy
    );

endmodule

/* design/divSqrtArbiter.sv */
//==========================================================
// Round-robin arbiter for the shared div/sqrt unit. Lane 0
// has priority after reset. At most one grant per cycle.
//==========================================================
`timescale 1ns/1ps
`include "fpIssue_cfg.svh"

module divSqrtArbiter (
    input  logic clk,
    input  logic reset,
    input  logic [`FP_ISSUE_WIDTH-1:0] divReq,
    output logic [`FP_ISSUE_WIDTH-1:0] divGrant
);
    localparam int PtrW = $clog2(`FP_ISSUE_WIDTH);

    logic [PtrW-1:0] lastGrant;
    logic [PtrW-1:0] grantIdx;

    // Search starts one lane past the last winner
    always_comb begin
        int idx;
        logic found;
        found = 1'b0;
        divGrant = '0;
        grantIdx = lastGrant;
        for (int k = 1; k <= `FP_ISSUE_WIDTH; k++) begin
            idx = (int'(lastGrant) + k) % `FP_ISSUE_WIDTH;
            if (!found && divReq[idx]) begin
                found = 1'b1;
                divGrant[idx] = 1'b1;
                grantIdx = PtrW'(idx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lastGrant <= PtrW'(`FP_ISSUE_WIDTH - 1);
        end else if (|divGrant) begin
            lastGrant <= grantIdx;
        end
    end

    grantOneHot: assert property (
        @(posedge clk) disable iff (reset) $onehot0(divGrant)
    );

endmodule

/* design/divSqrtUnit.sv */
//==========================================================
// Iterative unsigned divide and integer square root.
// Divide takes 17 cycles, sqrt 9. divStart is ignored while
// busy. Divide by zero yields all ones.
//==========================================================
`timescale 1ns/1ps
`include "fpIssue_cfg.svh"

module divSqrtUnit (
    input  logic clk,
    input  logic reset,
    input  logic divStart,
    input  FpIssuePkg::FpOpKind divKind,
    input  FpIssuePkg::FpTag divTag,
    input  FpIssuePkg::FpOperands divOperands,
    output logic divBusy,
    output logic divDone,
    output FpIssuePkg::FpTag doneTag,
    output FpIssuePkg::FpData divData
);
    import FpIssuePkg::*;

    localparam int W = `FP_DATA_WIDTH;
    localparam int CountW = $clog2(W + 1);

    logic [CountW-1:0] count;
    logic isSqrt;
    logic [W+1:0] acc;
    FpData work, root, divisor;
    logic [W+1:0] divShift, sqrtShift, sqrtTrial;

    // Next partial remainders for one step of each loop
    always_comb begin
        divShift = {acc[W:0], work[W-1]};
        sqrtShift = {acc[W-1:0], work[W-1:W-2]};
        sqrtTrial = {root, 2'b01};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            divBusy <= 1'b0;
            divDone <= 1'b0;
        end else begin
            divDone <= 1'b0;
            if (divStart && !divBusy) begin
                divBusy <= 1'b1;
                isSqrt <= (divKind == opSqrt);
                count <= (divKind == opSqrt) ? CountW'(W / 2) : CountW'(W);
                acc <= '0;
                root <= '0;
                work <= divOperands.divSqrt.dividend;
                divisor <= divOperands.divSqrt.divisor;
                doneTag <= divTag;
            end else if (divBusy && count != '0) begin
                count <= count - 1'b1;
                if (isSqrt) begin
                    work <= {work[W-3:0], 2'b00};
                    if (sqrtShift >= sqrtTrial) begin
                        acc <= sqrtShift - sqrtTrial;
                        root <= {root[W-2:0], 1'b1};
                    end else begin
                        acc <= sqrtShift;
                        root <= {root[W-2:0], 1'b0};
                    end
                // A zero divisor always subtracts, so quotient fills with ones
                end else if (divShift >= {2'b00, divisor}) begin
                    acc <= divShift - {2'b00, divisor};
                    work <= {work[W-2:0], 1'b1};
                end else begin
                    acc <= divShift;
                    work <= {work[W-2:0], 1'b0};
                end
            end else if (divBusy) begin
                divBusy <= 1'b0;
                divDone <= 1'b1;
                divData <= isSqrt ? root : work;
            end
        end
    end

endmodule

/* design/fpIssueTop.sv */
//==========================================================
// FP issue path top. Dispatch only while queueFull is low.
// Div results of flushed ops are still reported.
//==========================================================
`timescale 1ns/1ps
`include "fpIssue_cfg.svh"

module fpIssueTop (
    input  logic clk,
    input  logic reset,
    input  logic dispatchValid,
    input  FpIssuePkg::FpOpKind dispatchKind,
    input  FpIssuePkg::FpTag dispatchTag,
    input  FpIssuePkg::FpOperands dispatchOperands,
    output logic queueFull,
    input  logic stall,
    input  logic flushValid,
    input  logic flushAll,
    input  FpIssuePkg::FpTag flushHead,
    input  FpIssuePkg::FpTag flushTail,
    output logic [`FP_ISSUE_WIDTH-1:0] resultValid,
    output FpIssuePkg::FpTag resultTag [`FP_ISSUE_WIDTH],
    output FpIssuePkg::FpData resultData [`FP_ISSUE_WIDTH],
    output logic divDone,
    output FpIssuePkg::FpTag divTag,
    output FpIssuePkg::FpData divData
);
    import FpIssuePkg::*;

    FpIssueSlot issueSlot [`FP_ISSUE_WIDTH];
    FpQueueIndex issueIndex [`FP_ISSUE_WIDTH];
    logic [`FP_ISSUE_WIDTH-1:0] issueDone, issueReplay, divReq, divGrant;
    logic divStart, divBusy;
    FpOpKind startKind;
    FpTag startTag;
    FpOperands startOperands;

    fpIssueQueue fpIssueQueue_i (
        .clk(clk), .reset(reset),
        .dispatchValid(dispatchValid), .dispatchKind(dispatchKind),
        .dispatchTag(dispatchTag), .dispatchOperands(dispatchOperands),
        .queueFull(queueFull), .stall(stall),
        .flushValid(flushValid), .flushAll(flushAll),
        .flushHead(flushHead), .flushTail(flushTail),
        .issueSlot(issueSlot), .issueDone(issueDone),
        .issueReplay(issueReplay), .issueIndex(issueIndex)
    );

    fpIssueStage fpIssueStage_i (
        .clk(clk), .reset(reset), .stall(stall),
        .flushValid(flushValid), .flushAll(flushAll),
        .flushHead(flushHead), .flushTail(flushTail),
        .issueSlot(issueSlot), .issueDone(issueDone),
        .issueReplay(issueReplay), .issueIndex(issueIndex),
        .divReq(divReq), .divGrant(divGrant), .divBusy(divBusy),
        .divStart(divStart), .divKind(startKind), .divTag(startTag),
        .divOperands(startOperands),
        .resultValid(resultValid), .resultTag(resultTag), .resultData(resultData)
    );

    divSqrtArbiter divSqrtArbiter_i (
        .clk(clk), .reset(reset), .divReq(divReq), .divGrant(divGrant)
    );

    divSqrtUnit divSqrtUnit_i (
        .clk(clk), .reset(reset),
        .divStart(divStart), .divKind(startKind), .divTag(startTag),
        .divOperands(startOperands),
        .divBusy(divBusy), .divDone(divDone), .doneTag(divTag), .divData(divData)
    );

endmodule

/* bench/fpIssueTb.sv */
//==========================================================
// Testbench for the FP issue path. Run from the project
// root, it reads bench/fpIssue_tests.txt. Tags must be
// unique per run. Stall follows an LFSR, one bit a cycle.
//==========================================================
`timescale 1ns/1ps
`include "fpIssue_cfg.svh"

module fpIssueTb;
    import FpIssuePkg::*;

    localparam int MaxTests = 32;
    localparam int NumTags = 1 << `FP_TAG_WIDTH;
    localparam int Timeout = 2000;
    // Longer than the 17-cycle divide, catches late or repeated results
    localparam int DrainCycles = 40;

    logic clk, reset, dispatchValid, queueFull, stall;
    logic flushValid, flushAll, divDone;
    FpOpKind dispatchKind;
    FpTag dispatchTag, flushHead, flushTail, divTag;
    FpOperands dispatchOperands;
    logic [`FP_ISSUE_WIDTH-1:0] resultValid;
    FpTag resultTag [`FP_ISSUE_WIDTH];
    FpData resultData [`FP_ISSUE_WIDTH];
    FpData divData;

    // Scoreboard, indexed by test number
    string names [MaxTests];
    FpOpKind kinds [MaxTests];
    FpTag tags [MaxTests];
    FpData srcA [MaxTests], srcB [MaxTests], expects [MaxTests];
    bit flushIt [MaxTests], bad [MaxTests];
    int hits [MaxTests];
    // Test number for each tag, -1 when unused
    int tagToTest [NumTags];
    int numTests, errorCount;
    bit aborted;
    logic [31:0] lfsr;

    fpIssueTop fpIssueTop_i (
        .clk(clk), .reset(reset),
        .dispatchValid(dispatchValid), .dispatchKind(dispatchKind),
        .dispatchTag(dispatchTag), .dispatchOperands(dispatchOperands),
        .queueFull(queueFull), .stall(stall),
        .flushValid(flushValid), .flushAll(flushAll),
        .flushHead(flushHead), .flushTail(flushTail),
        .resultValid(resultValid), .resultTag(resultTag), .resultData(resultData),
        .divDone(divDone), .divTag(divTag), .divData(divData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] stepLfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Reference arithmetic, straight from the op definitions
    function automatic FpData modelResult(input FpOpKind kind, input FpData a,
                                          input FpData b);
        int root;
        root = 0;
        case (kind)
            opAdd: return a + b;
            opSub: return a - b;
            opMul: return a * b;
            opDiv: return (b == '0) ? '1 : a / b;
            default: begin
                while ((root + 1) * (root + 1) <= int'(a)) begin
                    root++;
                end
                return FpData'(root);
            end
        endcase
    endfunction

    function automatic bit parseKind(input string text, output FpOpKind kind);
        kind = opAdd;
        if (text == "add") kind = opAdd;
        else if (text == "sub") kind = opSub;
        else if (text == "mul") kind = opMul;
        else if (text == "div") kind = opDiv;
        else if (text == "sqrt") kind = opSqrt;
        else return 1'b0;
        return 1'b1;
    endfunction

    task automatic loadTests();
        int fd, tagVal, flushVal;
        string line, name, kindText;
        logic [15:0] a, b, e;
        FpOpKind kind;
        fd = $fopen("bench/fpIssue_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/fpIssue_tests.txt");
            aborted = 1'b1;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if ($sscanf(line, "%s %s %d %h %h %d %h", name, kindText, tagVal, a, b,
                        flushVal, e) != 7 || !parseKind(kindText, kind)) begin
                $display("Malformed test line: %s", line);
                errorCount++;
                continue;
            end
            if (numTests >= MaxTests || tagVal < 0 || tagVal >= NumTags ||
                    tagToTest[tagVal] >= 0) begin
                $display("Test %s has a bad or reused tag or exceeds the table", name);
                errorCount++;
                continue;
            end
            names[numTests] = name;
            kinds[numTests] = kind;
            tags[numTests] = FpTag'(tagVal);
            srcA[numTests] = a;
            srcB[numTests] = b;
            flushIt[numTests] = (flushVal != 0);
            expects[numTests] = e;
            if (modelResult(kind, a, b) !== e) begin
                $display("[ERROR] %s file value %h differs from rule value %h",
                         name, e, modelResult(kind, a, b));
                bad[numTests] = 1'b1;
            end
            tagToTest[tagVal] = numTests;
            numTests++;
        end
        $fclose(fd);
    endtask

    task automatic dispatchTest(input int t);
        int waited;
        waited = 0;
        while (queueFull && !aborted) begin
            @(posedge clk);
            #2;
            waited++;
            if (waited >= Timeout) begin
                $display("Timeout: %s found the queue full for %0d cycles", names[t], waited);
                aborted = 1'b1;
            end
        end
        if (!aborted) begin
            dispatchValid = 1'b1;
            dispatchKind = kinds[t];
            dispatchTag = tags[t];
            if (IsDivSqrt(kinds[t])) begin
                dispatchOperands.divSqrt.dividend = srcA[t];
                dispatchOperands.divSqrt.divisor = srcB[t];
            end else begin
                dispatchOperands.arith.srcA = srcA[t];
                dispatchOperands.arith.srcB = srcB[t];
            end
            @(posedge clk);
            #2;
            dispatchValid = 1'b0;
            // Entry is still in the queue during this cycle
            if (flushIt[t]) begin
                flushValid = 1'b1;
                flushHead = tags[t];
                flushTail = tags[t];
                @(posedge clk);
                #2;
                flushValid = 1'b0;
            end
        end
    endtask

    function automatic int firstOpen();
        for (int t = 0; t < numTests; t++) begin
            if (!flushIt[t] && hits[t] == 0) begin
                return t;
            end
        end
        return -1;
    endfunction

    task automatic waitForResults();
        int waited;
        waited = 0;
        while (firstOpen() >= 0 && !aborted) begin
            @(posedge clk);
            waited++;
            if (firstOpen() >= 0 && waited >= Timeout) begin
                $display("Timeout: %s has no result after %0d cycles",
                         names[firstOpen()], waited);
                aborted = 1'b1;
            end
        end
    endtask

    task automatic recordResult(input FpTag tag, input FpData data);
        int t;
        t = tagToTest[tag];
        if (t < 0) begin
            $display("Result %h arrived on tag %0d, which no test uses", data, tag);
            errorCount++;
        end else if (flushIt[t]) begin
            $display("%s was flushed before it started but reported a result", names[t]);
            bad[t] = 1'b1;
        end else if (hits[t] > 0) begin
            $display("%s reported a result more than once", names[t]);
            bad[t] = 1'b1;
        end else if (data !== expects[t]) begin
            $display("[ERROR] %s expected %h actual %h", names[t], expects[t], data);
            bad[t] = 1'b1;
        end else begin
            $display("PASS %s tag %0d result %h", names[t], tag, data);
        end
        if (t >= 0) begin
            hits[t]++;
        end
    endtask

    // Outputs are settled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            for (int l = 0; l < `FP_ISSUE_WIDTH; l++) begin
                if (resultValid[l]) begin
                    recordResult(resultTag[l], resultData[l]);
                end
            end
            if (divDone) begin
                recordResult(divTag, divData);
            end
        end
    end

    // Random stall, new bit each cycle; reset is read at the edge
    always @(posedge clk) begin
        if (reset) begin
            #2;
            stall = 1'b0;
        end else begin
            #2;
            lfsr = stepLfsr(lfsr);
            stall = lfsr[0];
        end
    end

    initial begin
        int passed;
        reset = 1'b1;
        stall = 1'b0;
        dispatchValid = 1'b0;
        dispatchKind = opAdd;
        dispatchTag = '0;
        dispatchOperands = '0;
        flushValid = 1'b0;
        flushAll = 1'b0;
        flushHead = '0;
        flushTail = '0;
        lfsr = 32'h6ef3;
        numTests = 0;
        errorCount = 0;
        aborted = 1'b0;
        passed = 0;
        for (int i = 0; i < MaxTests; i++) begin
            hits[i] = 0;
            bad[i] = 1'b0;
            flushIt[i] = 1'b0;
        end
        for (int i = 0; i < NumTags; i++) begin
            tagToTest[i] = -1;
        end
        loadTests();
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int t = 0; t < numTests && !aborted; t++) begin
            dispatchTest(t);
        end
        waitForResults();
        if (!aborted) begin
            repeat (DrainCycles) @(posedge clk);
        end
        for (int t = 0; t < numTests; t++) begin
            if (flushIt[t] && hits[t] == 0 && !aborted) begin
                $display("PASS %s flushed, no result", names[t]);
            end else if (!flushIt[t] && hits[t] == 0) begin
                $display("%s never produced a result", names[t]);
            end
            if (!bad[t] && hits[t] == (flushIt[t] ? 0 : 1)) begin
                passed++;
            end
        end
        $display("Tests run %0d, passed %0d, failed %0d, other errors %0d",
                 numTests, passed, numTests - passed, errorCount);
        if (passed == numTests && numTests > 0 && errorCount == 0 && !aborted) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+design
design/FpIssuePkg.sv
design/fpIssueQueue.sv
design/fpIssueStage.sv
design/divSqrtArbiter.sv
design/divSqrtUnit.sv
design/fpIssueTop.sv
bench/fpIssueTb.sv

/* bench/fpIssue_tests.txt */
# name kind tag srcA/dividend srcB/divisor flush expected (tag decimal, values hex)
# flush 1 flushes the op's own tag in the cycle after its dispatch, so no result is due
addBasic  add  1  0012 0034 0 0046
addWrap   add  2  ffff 0003 0 0002
subWrap   sub  3  0001 0002 0 ffff
mulLow    mul  4  0123 0045 0 4e6f
mulWrap   mul  5  ffff ffff 0 0001
divBasic  div  6  0064 0007 0 000e
divZero   div  7  1234 0000 0 ffff
sqrtBasic sqrt 8  0063 0000 0 0009
divPairA  div  9  1000 0010 0 0100
divPairB  div  10 7fff 0003 0 2aaa
addFlush  add  11 0001 0001 1 0002
divFlush  div  12 0100 0002 1 0080
subKeep   sub  13 0050 0010 0 0040
sqrtMax   sqrt 14 ffff 0000 0 00ff
divRunA   div  15 c350 00c8 0 00fa
sqrtRunB  sqrt 16 4000 0000 0 0080
divRunC   div  17 ffff 0010 0 0fff
divRunD   div  18 0007 0009 0 0000
sqrtRunE  sqrt 19 0002 0000 0 0001
mulTail   mul  20 00ff 00ff 0 fe01
